// File: all.f
+incdir+.
cpu_pkg.sv
decoder.sv
register_file.sv
hazard_unit.sv
alu.sv
pipeline_cpu.sv
tb_pipeline_cpu.sv

// File: alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module alu
    import cpu_pkg::*;
(
    input  word_t      a,
    input  word_t      b,
    input  alu_op_e    op,
    input  logic [4:0] shamt,
    output word_t      result
);

    logic less;  // Signed a < b

    assign less = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;       // Wraps, no overflow trap
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = {{(`CPU_XLEN-1){1'b0}}, less};
            ALU_SLL: result = b << shamt;  // Shifts rt, not rs
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Data path and address width in bits
`define CPU_XLEN 32

// Architectural registers, r0 hardwired to zero
`define CPU_REGS 32

// Byte step between sequential fetches
`define CPU_PC_STEP 4

// First fetch address once reset drops
`define CPU_RESET_PC 0

`endif

// File: cpu_pkg.sv
`default_nettype none
`include "cpu_cfg.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0]         word_t;     // Data and address word
    typedef logic [$clog2(`CPU_REGS)-1:0] reg_addr_t; // Register index

    typedef enum logic [5:0] {
        R_TYPE = 6'h00,  // Operation chosen by funct
        ADDIU  = 6'h09,  // Sign-extended immediate
        ANDI   = 6'h0c,  // Zero-extended immediate
        ORI    = 6'h0d,  // Zero-extended immediate
        LW     = 6'h23,
        SW     = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        SLL  = 6'h00,    // Shift rt by shamt
        ADDU = 6'h21,
        SUBU = 6'h23,
        AND  = 6'h24,
        OR   = 6'h25,
        XOR  = 6'h26,
        SLT  = 6'h2a     // Signed compare
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_SLL = 4'd6
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_REG = 2'd0,  // Value read in decode
        FWD_MEM = 2'd1,  // ALU result now in memory stage
        FWD_WB  = 2'd2   // Value being written back
    } fwd_sel_e;

    typedef struct packed {
        logic    reg_write;   // Writes dest at write-back
        logic    mem_read;    // Load
        logic    mem_write;   // Store
        logic    mem_to_reg;  // Write-back takes load data
        logic    alu_src;     // Operand b is the immediate
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t     ctrl;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t dest;
        logic [4:0] shamt;
        word_t     rs_data;
        word_t     rt_data;      // Also the store data
        word_t     imm;
    } id_ex_t;

    typedef struct packed {
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        logic      mem_to_reg;
        word_t     alu_result;   // Result or memory address
        word_t     store_data;
        reg_addr_t dest;
    } ex_mem_t;

    typedef struct packed {
        logic      reg_write;
        logic      mem_to_reg;
        word_t     load_data;
        word_t     alu_result;
        reg_addr_t dest;
    } mem_wb_t;

endpackage

`default_nettype wire

// File: decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module decoder
    import cpu_pkg::*;
(
    input  word_t     instr,
    output ctrl_t     ctrl,
    output reg_addr_t dest,
    output word_t     imm
);

    logic sign_ext;  // Immediate gets the sign of bit 15

    always_comb begin
        ctrl        = '0;              // Anything not recognised is a bubble
        ctrl.alu_op = ALU_ADD;
        dest        = instr[20:16];    // rt unless R-type
        sign_ext    = 1'b1;
        case (instr[31:26])
            R_TYPE: begin
                dest           = instr[15:11];  // rd
                ctrl.reg_write = 1'b1;
                case (instr[5:0])
                    ADDU:    ctrl.alu_op = ALU_ADD;
                    SUBU:    ctrl.alu_op = ALU_SUB;
                    AND:     ctrl.alu_op = ALU_AND;
                    OR:      ctrl.alu_op = ALU_OR;
                    XOR:     ctrl.alu_op = ALU_XOR;
                    SLT:     ctrl.alu_op = ALU_SLT;
                    SLL:     ctrl.alu_op = ALU_SLL;
                    default: ctrl.reg_write = 1'b0;  // Unknown funct
                endcase
            end
            ADDIU: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            ANDI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = ALU_AND;
                sign_ext       = 1'b0;
            end
            ORI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = ALU_OR;
                sign_ext       = 1'b0;
            end
            LW: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_src    = 1'b1;  // Address is base plus offset
            end
            SW: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            default: ;
        endcase
        imm = {{(`CPU_XLEN-16){sign_ext & instr[15]}}, instr[15:0]};
    end

endmodule

`default_nettype wire

// File: hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit
    import cpu_pkg::*;
(
    input  reg_addr_t id_rs,   // Sources of the instruction in decode
    input  reg_addr_t id_rt,
    input  id_ex_t    ex,
    input  ex_mem_t   mem,
    input  mem_wb_t   wb,
    output fwd_sel_e  fwd_rs,
    output fwd_sel_e  fwd_rt,
    output logic      stall
);

    // Youngest producer wins, r0 is never forwarded
    function automatic fwd_sel_e fwd_pick(
        input reg_addr_t src,
        input ex_mem_t   m,
        input mem_wb_t   w
    );
        fwd_sel_e sel;
        sel = FWD_REG;
        if (m.reg_write && m.dest != '0 && m.dest == src) begin
            sel = FWD_MEM;
        end else if (w.reg_write && w.dest != '0 && w.dest == src) begin
            sel = FWD_WB;
        end
        return sel;
    endfunction

    assign fwd_rs = fwd_pick(ex.rs, mem, wb);
    assign fwd_rt = fwd_pick(ex.rt, mem, wb);

    logic load_in_ex;  // Load data not ready until write-back

    assign load_in_ex = ex.ctrl.mem_read && (ex.dest != '0);

    // Hold decode one cycle behind a load it depends on
    assign stall = load_in_ex && (ex.dest == id_rs || ex.dest == id_rt);

endmodule

`default_nettype wire

// File: pipeline_cpu.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module pipeline_cpu
    import cpu_pkg::*;
(
    input  logic  clock,
    input  logic  rst,
    output word_t instr_addr,   // Fetch address
    input  word_t instr_data,   // Combinational from instr_addr
    output word_t data_addr,
    output word_t data_wdata,
    output logic  data_write,   // Written at the next edge
    output logic  data_read,
    input  word_t data_rdata    // Combinational while data_read
);

    word_t     pc;
    word_t     if_id_instr;     // Instruction in decode
    logic      if_id_valid;     // Decode register holds a fetched word
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    mem_wb_t   mem_wb;

    ctrl_t     id_ctrl;
    reg_addr_t id_dest;
    word_t     id_imm;
    word_t     id_rs_data;
    word_t     id_rt_data;
    fwd_sel_e  fwd_rs;
    fwd_sel_e  fwd_rt;
    logic      stall;           // Load-use interlock
    word_t     ex_a;
    word_t     ex_rt_val;       // Forwarded rt, also the store data
    word_t     ex_b;
    word_t     ex_result;
    word_t     wb_data;

    // Fetch
    assign instr_addr = pc;

    always_ff @(posedge clock) begin
        if (rst) begin
            pc          <= `CPU_RESET_PC;
            if_id_valid <= 1'b0;
        end else if (!stall) begin  // PC and decode hold on stall
            pc          <= pc + `CPU_PC_STEP;
            if_id_valid <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            if_id_instr <= instr_data;
        end
    end

    // Decode
    decoder u_decoder (
        .instr (if_id_instr),
        .ctrl  (id_ctrl),
        .dest  (id_dest),
        .imm   (id_imm)
    );

    register_file u_regs (
        .clock   (clock),
        .rst     (rst),
        .rs      (if_id_instr[25:21]),
        .rt      (if_id_instr[20:16]),
        .rs_data (id_rs_data),
        .rt_data (id_rt_data),
        .wr_en   (mem_wb.reg_write),
        .wr_addr (mem_wb.dest),
        .wr_data (wb_data)
    );

    hazard_unit u_hazard (
        .id_rs  (if_id_instr[25:21]),
        .id_rt  (if_id_instr[20:16]),
        .ex     (id_ex),
        .mem    (ex_mem),
        .wb     (mem_wb),
        .fwd_rs (fwd_rs),
        .fwd_rt (fwd_rt),
        .stall  (stall)
    );

    always_ff @(posedge clock) begin
        if (rst || stall || !if_id_valid) begin
            id_ex.ctrl <= '0;  // Bubble into execute
        end else begin
            id_ex.ctrl <= id_ctrl;
        end
        id_ex.rs      <= if_id_instr[25:21];
        id_ex.rt      <= if_id_instr[20:16];
        id_ex.dest    <= id_dest;
        id_ex.shamt   <= if_id_instr[10:6];
        id_ex.rs_data <= id_rs_data;
        id_ex.rt_data <= id_rt_data;
        id_ex.imm     <= id_imm;
    end

    // Execute
    function automatic word_t fwd_mux(
        input fwd_sel_e sel,
        input word_t    reg_val,
        input word_t    mem_val,
        input word_t    wb_val
    );
        word_t val;
        case (sel)
            FWD_MEM: val = mem_val;
            FWD_WB:  val = wb_val;
            default: val = reg_val;
        endcase
        return val;
    endfunction

    assign ex_a      = fwd_mux(fwd_rs, id_ex.rs_data, ex_mem.alu_result, wb_data);
    assign ex_rt_val = fwd_mux(fwd_rt, id_ex.rt_data, ex_mem.alu_result, wb_data);
    assign ex_b      = id_ex.ctrl.alu_src ? id_ex.imm : ex_rt_val;

    alu u_alu (
        .a      (ex_a),
        .b      (ex_b),
        .op     (id_ex.ctrl.alu_op),
        .shamt  (id_ex.shamt),
        .result (ex_result)
    );

    always_ff @(posedge clock) begin
        if (rst) begin
            ex_mem.reg_write  <= 1'b0;
            ex_mem.mem_read   <= 1'b0;
            ex_mem.mem_write  <= 1'b0;
            ex_mem.mem_to_reg <= 1'b0;
        end else begin
            ex_mem.reg_write  <= id_ex.ctrl.reg_write;
            ex_mem.mem_read   <= id_ex.ctrl.mem_read;
            ex_mem.mem_write  <= id_ex.ctrl.mem_write;
            ex_mem.mem_to_reg <= id_ex.ctrl.mem_to_reg;
        end
        ex_mem.alu_result <= ex_result;
        ex_mem.store_data <= ex_rt_val;
        ex_mem.dest       <= id_ex.dest;
    end

    // Memory
    assign data_addr  = ex_mem.alu_result;
    assign data_wdata = ex_mem.store_data;
    assign data_write = ex_mem.mem_write;
    assign data_read  = ex_mem.mem_read;

    always_ff @(posedge clock) begin
        if (rst) begin
            mem_wb.reg_write  <= 1'b0;
            mem_wb.mem_to_reg <= 1'b0;
        end else begin
            mem_wb.reg_write  <= ex_mem.reg_write;
            mem_wb.mem_to_reg <= ex_mem.mem_to_reg;
        end
        mem_wb.load_data  <= data_rdata;
        mem_wb.alu_result <= ex_mem.alu_result;
        mem_wb.dest       <= ex_mem.dest;
    end

    // Write-back
    assign wb_data = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

    a_mem_excl: assert property (@(posedge clock) disable iff (rst) !(data_write && data_read))
        else $error("data_write and data_read high together");

    // The bubble moves the load on, so the interlock clears next cycle
    a_stall_once: assert property (@(posedge clock) disable iff (rst) stall |=> !stall)
        else $error("load-use stall lasted two cycles");

endmodule

`default_nettype wire

// File: register_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module register_file
    import cpu_pkg::*;
(
    input  logic      clock,
    input  logic      rst,
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    output word_t     rs_data,
    output word_t     rt_data,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data
);

    word_t regs [`CPU_REGS];  // r0 is never written
    logic  wr_live;           // A real write lands this cycle

    assign wr_live = wr_en && (wr_addr != '0);

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < `CPU_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Write-through so decode sees the value retiring now
    assign rs_data = (wr_live && wr_addr == rs) ? wr_data : regs[rs];
    assign rt_data = (wr_live && wr_addr == rt) ? wr_data : regs[rt];

    // r0 reads zero even while write-back targets it
    a_r0_zero: assert property (@(posedge clock) disable iff (rst) (rs == '0) |-> (rs_data == '0))
        else $error("register 0 read nonzero");

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -f all.f \
    --top-module tb_pipeline_cpu -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^STATUS: PASS$" sim.log; then
    exit 0
fi
exit 1

// File: tb_pipeline_cpu.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module tb_pipeline_cpu
    import cpu_pkg::*;
();

    logic  clock;
    logic  rst;
    word_t instr_addr;
    word_t instr_data;
    word_t data_addr;
    word_t data_wdata;
    logic  data_write;
    logic  data_read;
    word_t data_rdata;

    word_t imem [256];           // Word-addressed program store
    word_t dmem [64];            // Loads from the low words, stores from 0x80 up
    word_t prog [$];             // Program table
    string exp_name [$];         // Expected store table
    word_t exp_addr [$];
    word_t exp_data [$];
    word_t obs_addr [$];         // Stores seen on the bus
    word_t obs_data [$];
    int    seed;
    int    checks;
    int    value_errs;
    int    timeouts;
    int    other_errs;
    int    cycle;                // Cycles since reset dropped
    int    repeats;              // Fetch addresses seen twice in a row
    word_t prev_pc;
    bit    timed_out;

    always #50 clock = ~clock;   // 100 ns period

    pipeline_cpu uut (
        .clock      (clock),
        .rst        (rst),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_write (data_write),
        .data_read  (data_read),
        .data_rdata (data_rdata)
    );

    always_comb instr_data = imem[instr_addr[9:2]];                   // Same-cycle fetch
    always_comb data_rdata = data_read ? dmem[data_addr[7:2]] : '0;  // Read while strobed

    always @(posedge clock) begin
        if (data_write) begin
            dmem[data_addr[7:2]] <= data_wdata;  // Lands on the edge after the strobe
        end
    end

    function automatic word_t r_type_word(input reg_addr_t rs, input reg_addr_t rt,
                                          input reg_addr_t rd, input logic [4:0] shamt,
                                          input funct_e fn);
        return {R_TYPE, rs, rt, rd, shamt, fn};
    endfunction

    function automatic word_t i_type_word(input opcode_e op, input reg_addr_t rs,
                                          input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t slt_rule(input word_t a, input word_t b);
        return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;  // Signed compare
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            value_errs++;
            $display("Error: %s data expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            value_errs++;
            $display("Error: %s address expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic expect_store(input string name, input word_t addr, input word_t data);
        exp_name.push_back(name);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic build_program();
        prog.push_back(i_type_word(SW, 5'd0, 5'd0, 16'h00bc));       // Earliest possible store
        prog.push_back(i_type_word(LW, 5'd0, 5'd1, 16'h0000));       // r1 = w0
        prog.push_back(i_type_word(LW, 5'd0, 5'd2, 16'h0004));       // r2 = w1
        prog.push_back(i_type_word(LW, 5'd0, 5'd3, 16'h0008));       // r3 = w2
        prog.push_back(i_type_word(LW, 5'd0, 5'd4, 16'h000c));       // r4 = w3
        prog.push_back(r_type_word(5'd1, 5'd2, 5'd5, 5'd0, ADDU));
        prog.push_back(i_type_word(SW, 5'd0, 5'd5, 16'h0080));       // Store data from mem stage
        prog.push_back(r_type_word(5'd1, 5'd2, 5'd6, 5'd0, SUBU));
        prog.push_back(r_type_word(5'd1, 5'd3, 5'd7, 5'd0, AND));
        prog.push_back(r_type_word(5'd2, 5'd3, 5'd8, 5'd0, OR));
        prog.push_back(r_type_word(5'd3, 5'd4, 5'd9, 5'd0, XOR));
        prog.push_back(i_type_word(SW, 5'd0, 5'd6, 16'h0084));
        prog.push_back(i_type_word(SW, 5'd0, 5'd7, 16'h0088));
        prog.push_back(i_type_word(SW, 5'd0, 5'd8, 16'h008c));
        prog.push_back(i_type_word(SW, 5'd0, 5'd9, 16'h0090));
        prog.push_back(i_type_word(ADDIU, 5'd0, 5'd10, 16'hfffb));   // r10 = -5
        prog.push_back(r_type_word(5'd10, 5'd1, 5'd11, 5'd0, SLT));  // Distance 1
        prog.push_back(r_type_word(5'd1, 5'd10, 5'd12, 5'd0, SLT));  // Distance 2
        prog.push_back(r_type_word(5'd0, 5'd2, 5'd13, 5'd7, SLL));
        prog.push_back(i_type_word(SW, 5'd0, 5'd10, 16'h0094));
        prog.push_back(i_type_word(SW, 5'd0, 5'd11, 16'h0098));
        prog.push_back(i_type_word(SW, 5'd0, 5'd12, 16'h009c));
        prog.push_back(i_type_word(SW, 5'd0, 5'd13, 16'h00a0));
        prog.push_back(i_type_word(ANDI, 5'd1, 5'd14, 16'h8f0f));    // High bit set
        prog.push_back(i_type_word(ORI, 5'd1, 5'd15, 16'h8001));
        prog.push_back(i_type_word(SW, 5'd0, 5'd14, 16'h00a4));
        prog.push_back(i_type_word(SW, 5'd0, 5'd15, 16'h00a8));
        prog.push_back(i_type_word(ADDIU, 5'd2, 5'd16, 16'h0123));
        prog.push_back(r_type_word(5'd16, 5'd3, 5'd17, 5'd0, ADDU));
        prog.push_back(r_type_word(5'd16, 5'd17, 5'd18, 5'd0, XOR)); // Distances 2 and 1
        prog.push_back(i_type_word(SW, 5'd0, 5'd17, 16'h00ac));
        prog.push_back(i_type_word(SW, 5'd0, 5'd18, 16'h00b0));
        prog.push_back(i_type_word(LW, 5'd0, 5'd19, 16'h0010));      // r19 = w4
        prog.push_back(r_type_word(5'd19, 5'd1, 5'd20, 5'd0, ADDU)); // Load-use
        prog.push_back(i_type_word(ADDIU, 5'd1, 5'd0, 16'h7fff));    // Into r0
        prog.push_back(r_type_word(5'd1, 5'd2, 5'd0, 5'd0, ADDU));
        prog.push_back(i_type_word(SW, 5'd0, 5'd20, 16'h00b4));
        prog.push_back(i_type_word(SW, 5'd0, 5'd0, 16'h00b8));       // Reads r0 during write-back
    endtask

    task automatic build_expected();
        word_t w0;
        word_t w1;
        word_t w2;
        word_t w3;
        word_t w4;
        word_t r16;
        w0  = dmem[0];
        w1  = dmem[1];
        w2  = dmem[2];
        w3  = dmem[3];
        w4  = dmem[4];
        r16 = w1 + 32'h0000_0123;
        expect_store("first_store", 32'hbc, 32'h0);
        expect_store("addu_store_fwd", 32'h80, w0 + w1);
        expect_store("subu", 32'h84, w0 - w1);
        expect_store("and", 32'h88, w0 & w2);
        expect_store("or", 32'h8c, w1 | w2);
        expect_store("xor", 32'h90, w2 ^ w3);
        expect_store("addiu_sign_ext", 32'h94, 32'hffff_fffb);
        expect_store("slt_neg_first", 32'h98, slt_rule(32'hffff_fffb, w0));
        expect_store("slt_neg_second", 32'h9c, slt_rule(w0, 32'hffff_fffb));
        expect_store("sll", 32'ha0, w1 << 7);
        expect_store("andi_zero_ext", 32'ha4, w0 & 32'h0000_8f0f);
        expect_store("ori_zero_ext", 32'ha8, w0 | 32'h0000_8001);
        expect_store("fwd_distance_1", 32'hac, r16 + w2);
        expect_store("fwd_distance_2", 32'hb0, r16 ^ (r16 + w2));
        expect_store("load_use", 32'hb4, w4 + w0);
        expect_store("r0_discard", 32'hb8, 32'h0);
    endtask

    task automatic wait_for_store(input int count, output bit expired);
        int c;
        c = 0;
        while (obs_data.size() < count && c < 100) begin  // Monitor pushes on the falling edge
            @(posedge clock);
            c++;
        end
        expired = (obs_data.size() < count);
    endtask

    task automatic wait_for_fetch_past(input word_t limit, output bit expired);
        int c;
        c = 0;
        while (instr_addr < limit && c < 200) begin
            @(negedge clock);
            c++;
        end
        expired = (instr_addr < limit);
    endtask

    // Bus monitor, sampled mid-cycle
    always @(negedge clock) begin
        if (rst) begin
            check_addr("reset_fetch", word_t'(`CPU_RESET_PC), instr_addr);
            if (data_write || data_read) begin
                other_errs++;
                $display("Data strobe high during reset");
            end
        end else begin
            if (cycle == 0) begin
                check_addr("first_fetch", word_t'(`CPU_RESET_PC), instr_addr);
            end else if (instr_addr == prev_pc) begin
                repeats++;                                   // Stall cycle
            end else if (instr_addr != prev_pc + `CPU_PC_STEP) begin
                other_errs++;
                $display("Fetch address jumped from %h to %h", prev_pc, instr_addr);
            end
            if (data_write && cycle < 3) begin               // Fetch in cycle 0, memory in 3
                other_errs++;
                $display("Store seen in cycle %0d, before the pipeline could produce one", cycle);
            end
            if (data_write) begin
                obs_addr.push_back(data_addr);
                obs_data.push_back(data_wdata);
            end
            prev_pc = instr_addr;
            cycle++;
        end
    end

    initial begin
        clock      = 1'b0;
        rst        = 1'b1;
        seed       = 74707;
        checks     = 0;
        value_errs = 0;
        timeouts   = 0;
        other_errs = 0;
        cycle      = 0;
        repeats    = 0;
        prev_pc    = '0;
        timed_out  = 1'b0;
        for (int i = 0; i < 64; i++) begin
            dmem[i] = $random(seed);
        end
        build_program();
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : '0;  // Zero word is a NOP
        end
        build_expected();
        repeat (2) @(posedge clock);
        rst <= 1'b0;
        for (int k = 0; k < exp_data.size() && !timed_out; k++) begin
            wait_for_store(k + 1, timed_out);
            if (timed_out) begin
                timeouts++;
                $display("Timeout waiting for store %0d (%s)", k, exp_name[k]);
            end else begin
                check_addr(exp_name[k], exp_addr[k], obs_addr[k]);
                check_word(exp_name[k], exp_data[k], obs_data[k]);
            end
        end
        if (!timed_out) begin
            wait_for_fetch_past(word_t'(prog.size() * `CPU_PC_STEP + 32), timed_out);
            if (timed_out) begin
                timeouts++;
                $display("Timeout waiting for fetch to run past the program");
            end else begin
                if (obs_data.size() != exp_data.size()) begin
                    other_errs++;
                    $display("Saw %0d stores where %0d were expected",
                             obs_data.size(), exp_data.size());
                end
                if (repeats != 1) begin
                    other_errs++;
                    $display("Fetch address repeated %0d times, one stall expected", repeats);
                end
            end
        end
        $display("Summary: %0d checks, %0d value errors, %0d timeouts, %0d other errors",
                 checks, value_errs, timeouts, other_errs);
        if (value_errs + timeouts + other_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
